//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_bpu_frontend
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the run prints the pass message
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
src/bpu_cfg_pkg.sv
src/bpu_types_pkg.sv
src/ftb.sv
src/dir_predictor.sv
src/bpu.sv
src/pc_gen.sv
src/bpu_frontend.sv
tb/tb_bpu_frontend.sv

//--- src/bpu.sv
//////////////////////////////
// Branch prediction unit
// P0 next-line block, P1 FTB
// redirect, FTQ training
//////////////////////////////
module bpu (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                backend_flush_i,
    // Prediction
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  pc_i,
    input  logic                                ftq_full_i,
    output bpu_types_pkg::bpu_ftq_t             ftq_p0_o,
    output bpu_types_pkg::bpu_ftq_t             ftq_p1_o,
    output bpu_types_pkg::bpu_ftq_meta_t        ftq_meta_o,
    // Training
    input  bpu_types_pkg::ftq_bpu_meta_t        ftq_meta_i,
    // Pc redirect
    output logic                                main_redirect_o,
    output logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  main_redirect_pc_o
);

    localparam int LenHi = bpu_cfg_pkg::LEN_WIDTH + 1;
    localparam int TagLo = bpu_cfg_pkg::FTB_IDX_WIDTH + 2;

    logic [bpu_cfg_pkg::PAGE_BITS-1:0]  page_off;
    logic [bpu_cfg_pkg::PAGE_BITS-1:0]  page_left;
    logic                               is_cross_page;
    logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] p1_pc_q;
    logic                               flush_delay_q;
    logic                               main_redirect;
    logic                               ftb_hit;
    bpu_types_pkg::ftb_entry_t          ftb_entry;
    logic                               predict_taken;
    logic                               predict_valid;
    bpu_types_pkg::bpu_ftq_meta_t       dir_meta;
    logic                               mispredict;
    logic                               ftb_update_valid;
    bpu_types_pkg::ftb_entry_t          ftb_update_entry;
    bpu_types_pkg::dir_update_t         dir_update;

    //////////////////////////////
    // P0 next-line block
    //////////////////////////////

    // A full block past this offset would leave the page
    assign page_off      = pc_i[bpu_cfg_pkg::PAGE_BITS-1:0];
    assign is_cross_page = page_off > bpu_cfg_pkg::PAGE_LAST_FULL;
    // Bytes up to the page end
    assign page_left     = '0 - page_off;

    always_comb begin
        ftq_p0_o = '0;
        if (!ftq_full_i) begin
            ftq_p0_o.valid    = 1'b1;
            ftq_p0_o.start_pc = pc_i;
            if (is_cross_page) begin
                ftq_p0_o.length = page_left[LenHi:2];
            end else begin
                ftq_p0_o.length = bpu_cfg_pkg::LEN_WIDTH'(bpu_cfg_pkg::FETCH_WIDTH);
            end
            // Page cut keeps the block inside one line
            ftq_p0_o.is_cross_cacheline = (pc_i[3:2] != 2'b00) & ~is_cross_page;
        end
    end

    //////////////////////////////
    // P1 redirect
    //////////////////////////////

    always_ff @(posedge clk) begin
        p1_pc_q <= pc_i;
    end

    // Kills the wrong-path P1 result after a flush or redirect
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            flush_delay_q <= 1'b0;
        end else begin
            flush_delay_q <= backend_flush_i | (main_redirect & ~ftq_full_i);
        end
    end

    assign main_redirect = predict_valid & ftb_hit & ~flush_delay_q;

    always_comb begin
        ftq_p1_o = '0;
        if (main_redirect && !ftq_full_i) begin
            ftq_p1_o.valid              = 1'b1;
            ftq_p1_o.start_pc           = p1_pc_q;
            // Word index difference, 3 bits wide
            ftq_p1_o.length             = ftb_entry.fall_through_address[LenHi:2]
                                        - p1_pc_q[LenHi:2];
            ftq_p1_o.is_cross_cacheline = ftb_entry.is_cross_cacheline;
            ftq_p1_o.predicted_taken    = predict_taken;
        end
    end

    assign main_redirect_o    = main_redirect;
    assign main_redirect_pc_o = predict_taken ? ftb_entry.jump_target_address
                                              : ftb_entry.fall_through_address;

    // Prediction metadata
    assign ftq_meta_o.valid             = ftb_hit | dir_meta.valid;
    assign ftq_meta_o.ftb_hit           = ftb_hit;
    assign ftq_meta_o.provider_ctr_bits = dir_meta.provider_ctr_bits;

    //////////////////////////////
    // Training decode
    //////////////////////////////

    assign mispredict = ftq_meta_i.predicted_taken ^ ftq_meta_i.is_taken;

    // Allocate on first taken miss, rewrite on pollution
    assign ftb_update_valid = ftq_meta_i.valid & ftq_meta_i.is_conditional
                            & ((mispredict & ~ftq_meta_i.ftb_hit)
                            | (ftq_meta_i.ftb_dirty & ftq_meta_i.ftb_hit));

    always_comb begin
        // Polluted entry written back invalid
        ftb_update_entry.valid                = ~(ftq_meta_i.ftb_dirty & ftq_meta_i.ftb_hit);
        ftb_update_entry.tag                  = ftq_meta_i.start_pc[bpu_cfg_pkg::ADDR_WIDTH-1:TagLo];
        ftb_update_entry.is_cross_cacheline   = ftq_meta_i.is_cross_cacheline;
        ftb_update_entry.jump_target_address  = ftq_meta_i.jump_target_address;
        ftb_update_entry.fall_through_address = ftq_meta_i.fall_through_address;
    end

    always_comb begin
        dir_update.valid        = ftq_meta_i.valid & (ftq_meta_i.ftb_hit | mispredict);
        dir_update.branch_taken = ftq_meta_i.is_taken;
        dir_update.bpu_meta     = ftq_meta_i.bpu_meta;
        // New branch trains as if weakly taken
        if (!ftq_meta_i.ftb_hit) begin
            dir_update.bpu_meta.provider_ctr_bits = bpu_cfg_pkg::CTR_WEAK_TAKEN;
        end
    end

    ftb i_ftb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .query_pc_i     (pc_i),
        .query_entry_o  (ftb_entry),
        .hit_o          (ftb_hit),
        .update_valid_i (ftb_update_valid),
        .update_pc_i    (ftq_meta_i.start_pc),
        .update_entry_i (ftb_update_entry)
    );

    dir_predictor i_dir_predictor (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pc_i            (pc_i),
        .predict_taken_o (predict_taken),
        .predict_valid_o (predict_valid),
        .bpu_meta_o      (dir_meta),
        .update_pc_i     (ftq_meta_i.start_pc),
        .update_i        (dir_update)
    );

endmodule

//--- src/bpu_cfg_pkg.sv
//////////////////////////////
// Branch predictor sizes
// Widths, table depths, counter
// encodings and page constants
//////////////////////////////
package bpu_cfg_pkg;

    // Address and fetch block
    localparam int ADDR_WIDTH  = 32;
    localparam int FETCH_WIDTH = 4;
    localparam int LEN_WIDTH   = $clog2(FETCH_WIDTH) + 1;

    // Table depths and index widths
    localparam int FTB_DEPTH     = 16;
    localparam int FTB_IDX_WIDTH = $clog2(FTB_DEPTH);
    localparam int BHT_DEPTH     = 64;
    localparam int BHT_IDX_WIDTH = $clog2(BHT_DEPTH);
    // Tag covers all pc bits above index and byte offset
    localparam int FTB_TAG_WIDTH = ADDR_WIDTH - FTB_IDX_WIDTH - 2;

    // Saturating counter encodings
    localparam int CTR_WIDTH = 2;
    localparam logic [CTR_WIDTH-1:0] CTR_RESET      = 2'b01;
    localparam logic [CTR_WIDTH-1:0] CTR_WEAK_TAKEN = 2'b10;

    // Page boundary, last offset where a full block still fits
    localparam int PAGE_BITS = 12;
    localparam logic [PAGE_BITS-1:0] PAGE_LAST_FULL = {{(PAGE_BITS - 4){1'b1}}, 4'h0};

    // Fetch start after reset
    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h1c00_0000;

endpackage

//--- src/bpu_frontend.sv
//////////////////////////////
// Fetch frontend top
// Pc generator and predictor
//////////////////////////////
module bpu_frontend (
    input  logic                                clk,
    input  logic                                rst_n_i,
    // Backend
    input  logic                                backend_flush_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  backend_flush_pc_i,
    // FTQ
    input  logic                                ftq_full_i,
    input  bpu_types_pkg::ftq_bpu_meta_t        ftq_meta_i,
    output bpu_types_pkg::bpu_ftq_t             ftq_p0_o,
    output bpu_types_pkg::bpu_ftq_t             ftq_p1_o,
    output bpu_types_pkg::bpu_ftq_meta_t        ftq_meta_o,
    // Redirect
    output logic                                main_redirect_o,
    output logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  main_redirect_pc_o
);

    logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] fetch_pc;

    // P0 block length steps the pc
    pc_gen i_pc_gen (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .backend_flush_i    (backend_flush_i),
        .backend_flush_pc_i (backend_flush_pc_i),
        .ftq_full_i         (ftq_full_i),
        .block_length_i     (ftq_p0_o.length),
        .redirect_i         (main_redirect_o),
        .redirect_pc_i      (main_redirect_pc_o),
        .fetch_pc_o         (fetch_pc)
    );

    bpu i_bpu (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .backend_flush_i    (backend_flush_i),
        .pc_i               (fetch_pc),
        .ftq_full_i         (ftq_full_i),
        .ftq_p0_o           (ftq_p0_o),
        .ftq_p1_o           (ftq_p1_o),
        .ftq_meta_o         (ftq_meta_o),
        .ftq_meta_i         (ftq_meta_i),
        .main_redirect_o    (main_redirect_o),
        .main_redirect_pc_o (main_redirect_pc_o)
    );

endmodule

//--- src/bpu_types_pkg.sv
//////////////////////////////
// Branch predictor types
// Fetch blocks, FTB entries,
// prediction and training records
//////////////////////////////
package bpu_types_pkg;

    // Fetch block handed to the FTQ
    typedef struct packed {
        logic                                 valid;
        logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]   start_pc;
        // Instructions in block, 1 to 4
        logic [bpu_cfg_pkg::LEN_WIDTH-1:0]    length;
        logic                                 is_cross_cacheline;
        logic                                 predicted_taken;
    } bpu_ftq_t;

    // One FTB slot
    typedef struct packed {
        logic                                 valid;
        logic [bpu_cfg_pkg::FTB_TAG_WIDTH-1:0] tag;
        logic                                 is_cross_cacheline;
        logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]   jump_target_address;
        logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]   fall_through_address;
    } ftb_entry_t;

    // Metadata sent along with a prediction
    typedef struct packed {
        logic                                 valid;
        logic                                 ftb_hit;
        // Counter value seen at prediction time
        logic [bpu_cfg_pkg::CTR_WIDTH-1:0]    provider_ctr_bits;
    } bpu_ftq_meta_t;

    // Training record returned by the FTQ
    typedef struct packed {
        logic                                 valid;
        logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]   start_pc;
        logic                                 is_conditional;
        logic                                 is_taken;
        logic                                 predicted_taken;
        logic                                 ftb_hit;
        // Entry found to be stale
        logic                                 ftb_dirty;
        logic                                 is_cross_cacheline;
        logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]   jump_target_address;
        logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]   fall_through_address;
        bpu_ftq_meta_t                        bpu_meta;
    } ftq_bpu_meta_t;

    // Counter update request
    typedef struct packed {
        logic                                 valid;
        logic                                 branch_taken;
        bpu_ftq_meta_t                        bpu_meta;
    } dir_update_t;

endpackage

//--- src/dir_predictor.sv
//////////////////////////////
// Bimodal direction predictor
// Saturating counters with a
// trained bit per slot
//////////////////////////////
module dir_predictor (
    input  logic                                clk,
    input  logic                                rst_n_i,
    // Lookup
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  pc_i,
    output logic                                predict_taken_o,
    output logic                                predict_valid_o,
    output bpu_types_pkg::bpu_ftq_meta_t        bpu_meta_o,
    // Update
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  update_pc_i,
    input  bpu_types_pkg::dir_update_t          update_i
);

    localparam int IdxHi = bpu_cfg_pkg::BHT_IDX_WIDTH + 1;
    localparam logic [bpu_cfg_pkg::CTR_WIDTH-1:0] CtrMax = '1;

    logic [bpu_cfg_pkg::CTR_WIDTH-1:0]     ctr_mem [bpu_cfg_pkg::BHT_DEPTH];
    logic [bpu_cfg_pkg::BHT_DEPTH-1:0]     trained_q;
    logic [bpu_cfg_pkg::CTR_WIDTH-1:0]     ctr_rd_q;
    logic                                  trained_rd_q;
    logic [bpu_cfg_pkg::BHT_IDX_WIDTH-1:0] query_idx;
    logic [bpu_cfg_pkg::BHT_IDX_WIDTH-1:0] update_idx;
    logic [bpu_cfg_pkg::CTR_WIDTH-1:0]     base_ctr;
    logic [bpu_cfg_pkg::CTR_WIDTH-1:0]     next_ctr;

    assign query_idx  = pc_i[IdxHi:2];
    assign update_idx = update_pc_i[IdxHi:2];

    // Start from the counter seen at prediction time
    assign base_ctr = update_i.bpu_meta.provider_ctr_bits;
    always_comb begin
        next_ctr = base_ctr;
        if (update_i.branch_taken && base_ctr != CtrMax) begin
            next_ctr = base_ctr + 1'b1;
        end else if (!update_i.branch_taken && base_ctr != '0) begin
            next_ctr = base_ctr - 1'b1;
        end
    end

    // Table write, every counter starts weakly not taken
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctr_mem   <= '{default: bpu_cfg_pkg::CTR_RESET};
            trained_q <= '0;
        end else if (update_i.valid) begin
            ctr_mem[update_idx]   <= next_ctr;
            trained_q[update_idx] <= 1'b1;
        end
    end

    // Registered lookup
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctr_rd_q     <= bpu_cfg_pkg::CTR_RESET;
            trained_rd_q <= 1'b0;
        end else begin
            ctr_rd_q     <= ctr_mem[query_idx];
            trained_rd_q <= trained_q[query_idx];
        end
    end

    // Top bit gives direction
    assign predict_taken_o              = ctr_rd_q[bpu_cfg_pkg::CTR_WIDTH-1];
    assign predict_valid_o              = trained_rd_q;
    assign bpu_meta_o.valid             = trained_rd_q;
    assign bpu_meta_o.ftb_hit           = 1'b0;
    assign bpu_meta_o.provider_ctr_bits = ctr_rd_q;

endmodule

//--- src/ftb.sv
//////////////////////////////
// Fetch target buffer
// Direct mapped, registered
// lookup, one write port
//////////////////////////////
module ftb (
    input  logic                                clk,
    input  logic                                rst_n_i,
    // Lookup
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  query_pc_i,
    output bpu_types_pkg::ftb_entry_t           query_entry_o,
    output logic                                hit_o,
    // Training write
    input  logic                                update_valid_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  update_pc_i,
    input  bpu_types_pkg::ftb_entry_t           update_entry_i
);

    localparam int IdxLo = 2;
    localparam int IdxHi = bpu_cfg_pkg::FTB_IDX_WIDTH + 1;

    logic [bpu_cfg_pkg::FTB_IDX_WIDTH-1:0] query_idx;
    logic [bpu_cfg_pkg::FTB_IDX_WIDTH-1:0] update_idx;
    logic [bpu_cfg_pkg::FTB_TAG_WIDTH-1:0] query_tag;

    // Valid bits kept apart so reset can clear them
    logic [bpu_cfg_pkg::FTB_DEPTH-1:0]     valid_q;
    bpu_types_pkg::ftb_entry_t             entry_mem [bpu_cfg_pkg::FTB_DEPTH];

    // Lookup pipeline registers
    logic                                  rd_valid_q;
    bpu_types_pkg::ftb_entry_t             rd_entry_q;
    logic [bpu_cfg_pkg::FTB_TAG_WIDTH-1:0] rd_tag_q;

    assign query_idx  = query_pc_i[IdxHi:IdxLo];
    assign query_tag  = query_pc_i[bpu_cfg_pkg::ADDR_WIDTH-1:IdxHi+1];
    assign update_idx = update_pc_i[IdxHi:IdxLo];

    // Valid array, invalid write used to drop polluted entries
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (update_valid_i) begin
            valid_q[update_idx] <= update_entry_i.valid;
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (update_valid_i) begin
            entry_mem[update_idx] <= update_entry_i;
        end
    end

    // Registered read, same cycle write not forwarded
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[query_idx];
        end
    end

    always_ff @(posedge clk) begin
        rd_entry_q <= entry_mem[query_idx];
        rd_tag_q   <= query_tag;
    end

    // P1 result
    always_comb begin
        query_entry_o       = rd_entry_q;
        query_entry_o.valid = rd_valid_q;
    end
    assign hit_o = rd_valid_q & (rd_entry_q.tag == rd_tag_q);

endmodule

//--- src/pc_gen.sv
//////////////////////////////
// Fetch pc generator
// Flush, redirect, advance or
// hold under back-pressure
//////////////////////////////
module pc_gen (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                backend_flush_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  backend_flush_pc_i,
    input  logic                                ftq_full_i,
    input  logic [bpu_cfg_pkg::LEN_WIDTH-1:0]   block_length_i,
    input  logic                                redirect_i,
    input  logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  redirect_pc_i,
    output logic [bpu_cfg_pkg::ADDR_WIDTH-1:0]  fetch_pc_o
);

    logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] fetch_pc_q;
    logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] seq_pc;

    // Next sequential block, length in words
    assign seq_pc = fetch_pc_q
                  + {{(bpu_cfg_pkg::ADDR_WIDTH - bpu_cfg_pkg::LEN_WIDTH - 2){1'b0}},
                     block_length_i, 2'b00};

    // Flush wins over redirect, back-pressure holds
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fetch_pc_q <= bpu_cfg_pkg::RESET_PC;
        end else if (backend_flush_i) begin
            fetch_pc_q <= backend_flush_pc_i;
        end else if (!ftq_full_i) begin
            if (redirect_i) begin
                fetch_pc_q <= redirect_pc_i;
            end else begin
                fetch_pc_q <= seq_pc;
            end
        end
    end

    assign fetch_pc_o = fetch_pc_q;

endmodule

//--- tb/tb_bpu_frontend.sv
//////////////////////////////
// Frontend testbench
// Step table against a model
// of the FTB and counter tables
//////////////////////////////
module tb_bpu_frontend;

    typedef logic [bpu_cfg_pkg::ADDR_WIDTH-1:0] addr_t;

    // Branch under training and its targets
    localparam addr_t BR_PC    = 32'h1c00_2040;
    localparam addr_t TGT_PC   = 32'h1c00_3000;
    localparam addr_t FT_PC    = 32'h1c00_2048;
    localparam addr_t BR2_PC   = 32'h1c00_4084;
    localparam addr_t TGT2_PC  = 32'h1c00_5000;
    localparam addr_t FT2_PC   = 32'h1c00_408c;
    localparam addr_t FLUSH_PC = 32'h1c00_6000;

    // One row of the step table
    typedef struct packed {
        logic       full;
        logic       flush;
        addr_t      flush_pc;
        logic       tr_valid;
        addr_t      tr_pc;
        logic       tr_taken;
        logic       tr_pred;
        logic       tr_hit;
        logic       tr_dirty;
        logic [1:0] tr_ctr;
        addr_t      jump;
        addr_t      fall;
        logic       exp_redir;
        addr_t      exp_rpc;
    } step_t;

    logic                         clk;
    logic                         rst_n;
    logic                         backend_flush;
    addr_t                        backend_flush_pc;
    logic                         ftq_full;
    bpu_types_pkg::ftq_bpu_meta_t ftq_meta_in;
    bpu_types_pkg::bpu_ftq_t      ftq_p0;
    bpu_types_pkg::bpu_ftq_t      ftq_p1;
    bpu_types_pkg::bpu_ftq_meta_t ftq_meta_out;
    logic                         main_redirect;
    addr_t                        main_redirect_pc;

    step_t       steps[$];
    string       names[$];
    logic        table_ready = 1'b0;
    logic [31:0] lfsr_state;

    // Model tables
    logic        m_ftb_valid [bpu_cfg_pkg::FTB_DEPTH];
    logic [bpu_cfg_pkg::FTB_TAG_WIDTH-1:0] m_ftb_tag [bpu_cfg_pkg::FTB_DEPTH];
    addr_t       m_ftb_jump [bpu_cfg_pkg::FTB_DEPTH];
    addr_t       m_ftb_fall [bpu_cfg_pkg::FTB_DEPTH];
    logic        m_ftb_cross [bpu_cfg_pkg::FTB_DEPTH];
    logic [1:0]  m_ctr [bpu_cfg_pkg::BHT_DEPTH];
    logic        m_trained [bpu_cfg_pkg::BHT_DEPTH];
    // Model pc and P1 lookup registers
    addr_t       m_pc;
    addr_t       m_p1_pc;
    addr_t       m_jump_q;
    addr_t       m_fall_q;
    logic        m_hit;
    logic        m_trained_q;
    logic        m_cross_q;
    logic        m_fd;
    logic [1:0]  m_ctr_q;

    bpu_frontend i_dut (
        .clk                (clk),
        .rst_n_i            (rst_n),
        .backend_flush_i    (backend_flush),
        .backend_flush_pc_i (backend_flush_pc),
        .ftq_full_i         (ftq_full),
        .ftq_meta_i         (ftq_meta_in),
        .ftq_p0_o           (ftq_p0),
        .ftq_p1_o           (ftq_p1),
        .ftq_meta_o         (ftq_meta_out),
        .main_redirect_o    (main_redirect),
        .main_redirect_pc_o (main_redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    // Half the pcs sit in the last line of a page
    function automatic addr_t random_pc();
        logic        near_end;
        logic [31:0] line;
        logic [31:0] word;
        near_end = (lfsr_bits(1) == 32'd1);
        line     = near_end ? 32'hff : lfsr_bits(8);
        word     = lfsr_bits(2);
        return {20'h1c010, line[7:0], word[1:0], 2'b00};
    endfunction

    // Words left before the page end, capped at a full block
    function automatic logic [2:0] block_length(input addr_t pc);
        logic [12:0] left;
        left = 13'h1000 - {1'b0, pc[11:0]};
        if (pc[11:0] > 12'hff0) begin
            return left[4:2];
        end else begin
            return 3'd4;
        end
    endfunction

    task automatic plain_step(input string name, input logic full, input logic flush,
                              input addr_t flush_pc, input logic exp_redir, input addr_t exp_rpc);
        step_t s;
        s           = '0;
        s.full      = full;
        s.flush     = flush;
        s.flush_pc  = flush_pc;
        s.exp_redir = exp_redir;
        s.exp_rpc   = exp_rpc;
        steps.push_back(s);
        names.push_back(name);
    endtask

    // Conditional branch record with no redirect expected
    task automatic training_step(input string name, input addr_t pc, input logic taken,
                                 input logic pred, input logic hit, input logic dirty,
                                 input logic [1:0] ctr, input addr_t jump, input addr_t fall);
        step_t s;
        s          = '0;
        s.tr_valid = 1'b1;
        s.tr_pc    = pc;
        s.tr_taken = taken;
        s.tr_pred  = pred;
        s.tr_hit   = hit;
        s.tr_dirty = dirty;
        s.tr_ctr   = ctr;
        s.jump     = jump;
        s.fall     = fall;
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic build_table();
        plain_step("reset_pc", 1'b0, 1'b0, '0, 1'b0, '0);
        plain_step("next_line", 1'b0, 1'b0, '0, 1'b0, '0);
        for (int i = 0; i < 8; i++) begin
            plain_step("lfsr_flush", 1'b0, 1'b1, random_pc(), 1'b0, '0);
        end
        plain_step("page_step_1", 1'b0, 1'b0, '0, 1'b0, '0);
        plain_step("page_step_2", 1'b0, 1'b0, '0, 1'b0, '0);
        // Back-pressure then resume
        for (int i = 0; i < 3; i++) begin
            plain_step("ftq_full", 1'b1, 1'b0, '0, 1'b0, '0);
        end
        plain_step("resume", 1'b0, 1'b0, '0, 1'b0, '0);
        // First taken branch
        training_step("alloc", BR_PC, 1'b1, 1'b0, 1'b0, 1'b0, 2'b01, TGT_PC, FT_PC);
        plain_step("flush_br", 1'b0, 1'b1, BR_PC, 1'b0, '0);
        plain_step("br_fetch", 1'b0, 1'b0, '0, 1'b0, '0);
        plain_step("br_redirect", 1'b0, 1'b0, '0, 1'b1, TGT_PC);
        plain_step("target_fetch", 1'b0, 1'b0, '0, 1'b0, '0);
        plain_step("after_target", 1'b0, 1'b0, '0, 1'b0, '0);
        // Counter walks down to not taken
        training_step("not_taken_1", BR_PC, 1'b0, 1'b1, 1'b1, 1'b0, 2'b11, TGT_PC, FT_PC);
        training_step("not_taken_2", BR_PC, 1'b0, 1'b1, 1'b1, 1'b0, 2'b10, TGT_PC, FT_PC);
        plain_step("flush_br_2", 1'b0, 1'b1, BR_PC, 1'b0, '0);
        plain_step("br_fetch_2", 1'b0, 1'b0, '0, 1'b0, '0);
        plain_step("fall_redirect", 1'b0, 1'b0, '0, 1'b1, FT_PC);
        plain_step("fall_fetch", 1'b0, 1'b0, '0, 1'b0, '0);
        // Polluted entry dropped
        training_step("polluted", BR_PC, 1'b0, 1'b0, 1'b1, 1'b1, 2'b01, TGT_PC, FT_PC);
        plain_step("flush_br_3", 1'b0, 1'b1, BR_PC, 1'b0, '0);
        plain_step("br_fetch_3", 1'b0, 1'b0, '0, 1'b0, '0);
        plain_step("no_redirect", 1'b0, 1'b0, '0, 1'b0, '0);
        // Flush on top of a pending hit
        training_step("alloc_2", BR2_PC, 1'b1, 1'b0, 1'b0, 1'b0, 2'b01, TGT2_PC, FT2_PC);
        plain_step("flush_br2", 1'b0, 1'b1, BR2_PC, 1'b0, '0);
        plain_step("br2_flush", 1'b0, 1'b1, FLUSH_PC, 1'b0, '0);
        plain_step("hit_killed", 1'b0, 1'b0, '0, 1'b0, '0);
        plain_step("flush_target", 1'b0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic model_reset();
        for (int i = 0; i < bpu_cfg_pkg::FTB_DEPTH; i++) begin
            m_ftb_valid[i] = 1'b0;
        end
        for (int i = 0; i < bpu_cfg_pkg::BHT_DEPTH; i++) begin
            m_ctr[i]     = bpu_cfg_pkg::CTR_RESET;
            m_trained[i] = 1'b0;
        end
        m_pc        = bpu_cfg_pkg::RESET_PC;
        m_p1_pc     = '0;
        m_jump_q    = '0;
        m_fall_q    = '0;
        m_hit       = 1'b0;
        m_trained_q = 1'b0;
        m_cross_q   = 1'b0;
        m_fd        = 1'b0;
        m_ctr_q     = bpu_cfg_pkg::CTR_RESET;
    endtask

    task automatic drive_step(input step_t s);
        bpu_types_pkg::ftq_bpu_meta_t rec;
        rec                            = '0;
        rec.valid                      = s.tr_valid;
        rec.start_pc                   = s.tr_pc;
        rec.is_conditional             = s.tr_valid;
        rec.is_taken                   = s.tr_taken;
        rec.predicted_taken            = s.tr_pred;
        rec.ftb_hit                    = s.tr_hit;
        rec.ftb_dirty                  = s.tr_dirty;
        rec.is_cross_cacheline         = (s.tr_pc[3:2] != 2'b00);
        rec.jump_target_address        = s.jump;
        rec.fall_through_address       = s.fall;
        rec.bpu_meta.valid             = s.tr_valid;
        rec.bpu_meta.ftb_hit           = s.tr_hit;
        rec.bpu_meta.provider_ctr_bits = s.tr_ctr;
        ftq_full         <= s.full;
        backend_flush    <= s.flush;
        backend_flush_pc <= s.flush_pc;
        ftq_meta_in      <= rec;
    endtask

    task automatic check_outputs(input string name, input step_t s);
        logic       redir;
        addr_t      rpc;
        logic [2:0] p1_len;
        redir  = m_trained_q & m_hit & ~m_fd;
        rpc    = m_ctr_q[1] ? m_jump_q : m_fall_q;
        p1_len = m_fall_q[4:2] - m_p1_pc[4:2];
        check({name, " table redirect"}, 64'(s.exp_redir), 64'(main_redirect));
        check({name, " model redirect"}, 64'(redir), 64'(main_redirect));
        check({name, " meta ftb_hit"}, 64'(m_hit), 64'(ftq_meta_out.ftb_hit));
        check({name, " meta valid"}, 64'(m_hit | m_trained_q), 64'(ftq_meta_out.valid));
        check({name, " meta ctr"}, 64'(m_ctr_q), 64'(ftq_meta_out.provider_ctr_bits));
        if (s.exp_redir) begin
            check({name, " table redirect pc"}, 64'(s.exp_rpc), 64'(main_redirect_pc));
        end
        if (redir) begin
            check({name, " model redirect pc"}, 64'(rpc), 64'(main_redirect_pc));
        end
        if (s.full) begin
            check({name, " p0 idle"}, 64'd0, 64'(ftq_p0));
            check({name, " p1 idle"}, 64'd0, 64'(ftq_p1));
        end else begin
            check({name, " p0 valid"}, 64'd1, 64'(ftq_p0.valid));
            check({name, " p0 start_pc"}, 64'(m_pc), 64'(ftq_p0.start_pc));
            check({name, " p0 length"}, 64'(block_length(m_pc)), 64'(ftq_p0.length));
            check({name, " p0 cross"},
                  64'((m_pc[3:2] != 2'b00) && !(m_pc[11:0] > 12'hff0)),
                  64'(ftq_p0.is_cross_cacheline));
            check({name, " p0 taken"}, 64'd0, 64'(ftq_p0.predicted_taken));
            if (redir) begin
                check({name, " p1 valid"}, 64'd1, 64'(ftq_p1.valid));
                check({name, " p1 start_pc"}, 64'(m_p1_pc), 64'(ftq_p1.start_pc));
                check({name, " p1 length"}, 64'(p1_len), 64'(ftq_p1.length));
                check({name, " p1 cross"}, 64'(m_cross_q), 64'(ftq_p1.is_cross_cacheline));
                check({name, " p1 taken"}, 64'(m_ctr_q[1]), 64'(ftq_p1.predicted_taken));
            end else begin
                check({name, " p1 idle"}, 64'd0, 64'(ftq_p1));
            end
        end
    endtask

    // One clock edge of the reference model
    task automatic model_clock(input step_t s);
        logic [3:0] fi;
        logic [5:0] bi;
        logic       redir;
        logic       mis;
        logic [1:0] base;
        addr_t      npc;
        redir = m_trained_q & m_hit & ~m_fd;
        if (s.flush) begin
            npc = s.flush_pc;
        end else if (!s.full && redir) begin
            npc = m_ctr_q[1] ? m_jump_q : m_fall_q;
        end else if (!s.full) begin
            npc = m_pc + addr_t'({block_length(m_pc), 2'b00});
        end else begin
            npc = m_pc;
        end
        m_fd = s.flush | (redir & ~s.full);
        // Lookup reads the tables before this edge's writes
        fi          = m_pc[5:2];
        bi          = m_pc[7:2];
        m_hit       = m_ftb_valid[fi] && (m_ftb_tag[fi] == m_pc[31:6]);
        m_jump_q    = m_ftb_jump[fi];
        m_fall_q    = m_ftb_fall[fi];
        m_cross_q   = m_ftb_cross[fi];
        m_ctr_q     = m_ctr[bi];
        m_trained_q = m_trained[bi];
        m_p1_pc     = m_pc;
        if (s.tr_valid) begin
            mis = s.tr_taken ^ s.tr_pred;
            fi  = s.tr_pc[5:2];
            bi  = s.tr_pc[7:2];
            if ((mis && !s.tr_hit) || (s.tr_dirty && s.tr_hit)) begin
                m_ftb_valid[fi] = !(s.tr_dirty && s.tr_hit);
                m_ftb_tag[fi]   = s.tr_pc[31:6];
                m_ftb_jump[fi]  = s.jump;
                m_ftb_fall[fi]  = s.fall;
                m_ftb_cross[fi] = (s.tr_pc[3:2] != 2'b00);
            end
            if (s.tr_hit || mis) begin
                base = s.tr_hit ? s.tr_ctr : bpu_cfg_pkg::CTR_WEAK_TAKEN;
                if (s.tr_taken && base != 2'b11) begin
                    base = base + 2'd1;
                end else if (!s.tr_taken && base != 2'b00) begin
                    base = base - 2'd1;
                end
                m_ctr[bi]     = base;
                m_trained[bi] = 1'b1;
            end
        end
        m_pc = npc;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        rst_n            = 1'b0;
        backend_flush    = 1'b0;
        backend_flush_pc = '0;
        ftq_full         = 1'b0;
        ftq_meta_in      = '0;
        lfsr_state       = 32'hcc92;
        build_table();
        table_ready = 1'b1;
        model_reset();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // Inputs change on rising edges and outputs are sampled on falling edges
        for (int k = 0; k < steps.size(); k++) begin
            drive_step(steps[k]);
            @(negedge clk);
            check_outputs(names[k], steps[k]);
            model_clock(steps[k]);
            @(posedge clk);
        end
        $display("TEST PASS");
        $finish;
    end

    // Watchdog allows 20 cycles per step plus reset
    initial begin
        wait (table_ready);
        repeat (steps.size() * 20 + 4) @(posedge clk);
        $display("Timeout: the step table did not complete in the allowed cycles");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
